// File: filelist.f
rtl/hart_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/hart.sv
test/hart_checker.sv
test/tb_hart.sv

// File: run_sim.sh
#!/bin/sh
# builds the hart testbench with Verilator, runs it and judges the run from its log
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps -Wno-fatal --top-module tb_hart -f filelist.f
./obj_dir/Vtb_hart | tee sim.log

if grep -qx "TEST OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// File: test/tb_hart.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hart;

  localparam int PROG_LEN           = 200;  // random instructions ahead of the ebreak
  localparam int IMEM_WORDS         = 256;
  localparam int DMEM_WORDS         = 64;   // data region at byte addresses 0 to 252
  localparam int FIRST_RETIRE_LIMIT = 50;
  localparam int RUN_LIMIT          = 2000;

  logic              clk = 1'b0;
  logic              rst = 1'b1;
  hart_pkg::word_t   imem_rdata = hart_pkg::NOP_INST;
  hart_pkg::word_t   dmem_rdata = '0;
  hart_pkg::word_t   imem_raddr, dmem_addr, dmem_wdata;
  logic              dmem_ren, dmem_wen;
  logic [3:0]        dmem_mask;
  hart_pkg::retire_t retire;

  hart_pkg::word_t imem [IMEM_WORDS];
  hart_pkg::word_t dmem [DMEM_WORDS];
  hart_pkg::word_t data_init [DMEM_WORDS];
  logic            dmem_loaded = 1'b0;
  logic [7:0]      imem_req_q = '0;  // word index presented at the last rising edge
  logic [5:0]      dmem_req_q = '0;
  logic            dmem_wen_q = 1'b0;
  hart_pkg::word_t dmem_wdata_q = '0;

  logic   chk_done;
  int     retired, checks, errors;
  integer seed = 32'h8ecc_2e6f;
  int     cycles;
  logic   timed_out;

  always #5 clk = ~clk;

  hart i_hart (
    .i_clk        (clk),
    .i_rst        (rst),
    .i_imem_rdata (imem_rdata),
    .i_dmem_rdata (dmem_rdata),
    .o_imem_raddr (imem_raddr),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_wdata (dmem_wdata),
    .o_dmem_ren   (dmem_ren),
    .o_dmem_wen   (dmem_wen),
    .o_dmem_mask  (dmem_mask),
    .o_retire     (retire)
  );

  hart_checker i_checker (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_retire    (retire),
    .i_dmem_ren  (dmem_ren),
    .i_dmem_wen  (dmem_wen),
    .i_dmem_mask (dmem_mask),
    .i_program   (imem),
    .i_data_init (data_init),
    .o_done      (chk_done),
    .o_retired   (retired),
    .o_checks    (checks),
    .o_errors    (errors)
  );

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // sel 0 to 7 follows funct3, 8 is sub and 9 is sra
  function automatic hart_pkg::word_t op_inst(input int sel, input hart_pkg::reg_addr_t rd,
                                              input hart_pkg::reg_addr_t rs1,
                                              input hart_pkg::reg_addr_t rs2);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = 3'(sel);
    f7 = 7'h00;
    if (sel == 8) begin
      f3 = 3'd0;
      f7 = 7'h20;
    end else if (sel == 9) begin
      f3 = 3'd5;
      f7 = 7'h20;
    end
    return {f7, rs2, rs1, f3, rd, hart_pkg::OPCODE_OP};
  endfunction

  // immediate forms, shifts get a clean shamt field and sel 8 is srai
  function automatic hart_pkg::word_t imm_inst(input int sel, input hart_pkg::reg_addr_t rd,
                                               input hart_pkg::reg_addr_t rs1,
                                               input logic [11:0] imm12, input logic [4:0] shamt);
    logic [2:0]  f3;
    logic [11:0] imm;
    f3  = 3'(sel);
    imm = imm12;
    if (f3 == 3'd1 || f3 == 3'd5) begin
      imm = {7'h00, shamt};
    end
    if (sel == 8) begin
      f3  = 3'd5;
      imm = {7'h20, shamt};
    end
    return {imm, rs1, f3, rd, hart_pkg::OPCODE_OP_IMM};
  endfunction

  task automatic build_program();
    int                  kind;
    hart_pkg::reg_addr_t rd, rs1, rs2;
    logic [11:0]         imm, off;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = hart_pkg::NOP_INST;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      data_init[i] = 32'h1357_9bdf ^ (32'(i) * 32'h0104_1041);  // each index bit shows up
    end
    for (int n = 0; n < PROG_LEN; n++) begin
      kind = (n == 0) ? 6 : rand_below(16);  // the first instruction stays off the data bus
      rd   = hart_pkg::reg_addr_t'(rand_below(8));  // x0 to x7 keeps dependencies dense
      rs1  = hart_pkg::reg_addr_t'(rand_below(8));
      rs2  = hart_pkg::reg_addr_t'(rand_below(8));
      imm  = 12'(rand_below(4096));
      off  = 12'(rand_below(DMEM_WORDS) * 4);  // word aligned offset from x0
      if (kind < 6) begin
        imem[n] = op_inst(rand_below(10), rd, rs1, rs2);
      end else if (kind < 11) begin
        imem[n] = imm_inst(rand_below(9), rd, rs1, imm, 5'(rand_below(32)));
      end else if (kind == 11) begin
        imem[n] = {20'(rand_below(1 << 20)), rd, hart_pkg::OPCODE_LUI};
      end else if (kind < 14) begin
        imem[n] = {off, 5'd0, 3'b010, rd, hart_pkg::OPCODE_LOAD};
      end else begin
        imem[n] = {off[11:5], rs2, 5'd0, 3'b010, off[4:0], hart_pkg::OPCODE_STORE};
      end
    end
    imem[PROG_LEN] = hart_pkg::EBREAK_INST;
  endtask

  // both memories answer at the falling edge for the address seen at the rising edge before
  always @(negedge clk) begin
    if (!dmem_loaded) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] = data_init[i];
      end
      dmem_loaded = 1'b1;
    end
    if (dmem_wen_q) begin
      dmem[dmem_req_q] = dmem_wdata_q;  // store taken at the edge just past
    end
    imem_rdata   = imem[imem_req_q];
    dmem_rdata   = dmem[dmem_req_q];
    imem_req_q   = imem_raddr[9:2];  // outputs are steady here until the next rising edge
    dmem_req_q   = dmem_addr[7:2];
    dmem_wen_q   = dmem_wen === 1'b1;
    dmem_wdata_q = dmem_wdata;
  end

  initial begin
    timed_out = 1'b0;
    build_program();
    repeat (16) @(negedge clk);
    rst = 1'b0;
    cycles = 0;
    while (retired == 0 && cycles < FIRST_RETIRE_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (retired == 0) begin
      $display("timeout: nothing retired within %0d cycles after reset", FIRST_RETIRE_LIMIT);
      timed_out = 1'b1;
    end else begin
      cycles = 0;
      while (chk_done !== 1'b1 && cycles < RUN_LIMIT) begin
        @(negedge clk);
        cycles++;
      end
      if (chk_done !== 1'b1) begin
        $display("timeout: the ebreak did not retire within %0d cycles", RUN_LIMIT);
        timed_out = 1'b1;
      end
    end
    $display("retired %0d, checks %0d, errors %0d", retired, checks, errors);
    if (!timed_out && errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/hart_checker.sv
`timescale 1ns/1ps
`default_nettype none

// watches the retire port and replays the same program on an instruction-level model
module hart_checker (
  input  wire                     i_clk,
  input  wire                     i_rst,
  input  wire hart_pkg::retire_t  i_retire,
  input  wire                     i_dmem_ren,
  input  wire                     i_dmem_wen,
  input  wire [3:0]               i_dmem_mask,
  input  wire hart_pkg::word_t    i_program [256],
  input  wire hart_pkg::word_t    i_data_init [64],
  output logic                    o_done,
  output int                      o_retired,
  output int                      o_checks,
  output int                      o_errors
);

  localparam int HALT_COUNT = 201;  // 200 random instructions and the closing ebreak

  hart_pkg::word_t regs [32];  // architectural registers of the model, x0 is never written
  hart_pkg::word_t mem [64];   // data region as the model sees it
  hart_pkg::word_t pc;         // pc of the next instruction expected to retire
  int              checks [5];
  int              errors [5];
  logic            bus_ren_q, bus_wen_q;  // data bus while the retiring instruction was in memory
  logic [3:0]      bus_mask_q;

  function automatic string test_name(input int t);
    case (t)
      0: return "reset_quiet";
      1: return "alu_results";
      2: return "dependent_operands";
      3: return "store_load";
      default: return "pc_and_halt";
    endcase
  endfunction

  task automatic report_test(input int t);
    $display("test %-18s %5d checks %3d errors  %s", test_name(t), checks[t], errors[t],
             errors[t] == 0 ? "pass" : "fail");
  endtask

  task automatic check_word(input int t, input string name, input hart_pkg::word_t got,
                            input hart_pkg::word_t exp);
    checks[t]++;
    if (got !== exp) begin  // an unknown value counts as a mismatch
      errors[t]++;
      $display("** Error at %0t: %s = %08h, expected %08h", $time, name, got, exp);
    end
  endtask

  // rv32i alu semantics, alt selects sub and sra
  function automatic hart_pkg::word_t alu(input logic [2:0] f3, input logic alt,
                                          input hart_pkg::word_t a, input hart_pkg::word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // executes the next program word on the model and compares the retired record with it
  task automatic check_record();
    hart_pkg::word_t     inst, a, b, imm_i, imm_s, res, addr;
    logic [6:0]          opc;
    hart_pkg::reg_addr_t ra1, ra2, rd;
    logic                is_op, is_imm, is_load, is_store, is_halt, writes;
    int                  grp;
    inst     = i_program[pc[9:2]];
    opc      = inst[6:0];
    is_op    = opc == hart_pkg::OPCODE_OP;
    is_imm   = opc == hart_pkg::OPCODE_OP_IMM;
    is_load  = opc == hart_pkg::OPCODE_LOAD;
    is_store = opc == hart_pkg::OPCODE_STORE;
    is_halt  = inst == hart_pkg::EBREAK_INST;
    writes   = is_op || is_imm || is_load || opc == hart_pkg::OPCODE_LUI;
    ra1      = (is_op || is_imm || is_load || is_store) ? inst[19:15] : 5'd0;
    ra2      = (is_op || is_store) ? inst[24:20] : 5'd0;  // unused sources report x0
    rd       = writes ? inst[11:7] : 5'd0;
    a        = regs[ra1];
    b        = regs[ra2];
    imm_i    = {{20{inst[31]}}, inst[31:20]};
    imm_s    = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    addr     = a + (is_store ? imm_s : imm_i);
    grp      = (is_load || is_store) ? 3 : (is_halt ? 4 : 1);
    case (opc)
      hart_pkg::OPCODE_OP:     res = alu(inst[14:12], inst[30], a, b);
      hart_pkg::OPCODE_OP_IMM: res = alu(inst[14:12], inst[14:12] == 3'd5 && inst[30], a, imm_i);
      hart_pkg::OPCODE_LUI:    res = {inst[31:12], 12'd0};
      hart_pkg::OPCODE_LOAD:   res = mem[addr[7:2]];
      default:                 res = '0;
    endcase
    if (o_retired == 0) begin
      check_word(0, "retire.pc", i_retire.pc, hart_pkg::RESET_ADDR);
    end
    check_word(4, "retire.pc", i_retire.pc, pc);
    check_word(4, "retire.next_pc", i_retire.next_pc, pc + 32'd4);
    check_word(4, "retire.inst", i_retire.inst, inst);
    check_word(4, "retire.halt", 32'(i_retire.halt), 32'(is_halt));
    check_word(2, "retire.rs1_raddr", 32'(i_retire.rs1_raddr), 32'(ra1));
    check_word(2, "retire.rs2_raddr", 32'(i_retire.rs2_raddr), 32'(ra2));
    check_word(2, "retire.rs1_rdata", i_retire.rs1_rdata, a);  // stale data means a missed stall
    check_word(2, "retire.rs2_rdata", i_retire.rs2_rdata, b);
    check_word(grp, "retire.rd_waddr", 32'(i_retire.rd_waddr), 32'(rd));
    if (rd != 5'd0) begin
      check_word(grp, "retire.rd_wdata", i_retire.rd_wdata, res);
    end
    check_word(grp, "retire.dmem_ren", 32'(i_retire.dmem_ren), 32'(is_load));
    check_word(grp, "retire.dmem_wen", 32'(i_retire.dmem_wen), 32'(is_store));
    check_word(grp, "o_dmem_ren", 32'(bus_ren_q), 32'(is_load));
    check_word(grp, "o_dmem_wen", 32'(bus_wen_q), 32'(is_store));
    if (is_load || is_store) begin
      check_word(3, "retire.dmem_addr", i_retire.dmem_addr, addr);
      check_word(3, "retire.dmem_mask", 32'(i_retire.dmem_mask), 32'hf);
      check_word(3, "o_dmem_mask", 32'(bus_mask_q), 32'hf);
    end
    if (is_load) begin
      check_word(3, "retire.dmem_rdata", i_retire.dmem_rdata, res);
    end
    if (is_store) begin
      check_word(3, "retire.dmem_wdata", i_retire.dmem_wdata, b);
      mem[addr[7:2]] = b;
    end
    if (rd != 5'd0) begin
      regs[rd] = res;
    end
    pc = pc + 32'd4;
    o_retired++;
    if (o_retired == 1) begin
      report_test(0);  // the reset window closes with the first retire
    end
    if (i_retire.halt) begin  // the hart's own halt flag ends the run, so its position is counted
      check_word(4, "retired count", o_retired, HALT_COUNT);
      for (int t = 1; t < 5; t++) begin
        report_test(t);
      end
      o_done = 1'b1;
    end
  endtask

  // sampled at the rising edge, where retire and the data bus still show the settled cycle
  always @(posedge i_clk) begin
    if (i_rst) begin
      pc        = hart_pkg::RESET_ADDR;
      o_done    = 1'b0;
      o_retired = 0;
      for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
      end
      for (int i = 0; i < 64; i++) begin
        mem[i] = i_data_init[i];
      end
      for (int t = 0; t < 5; t++) begin
        checks[t] = 0;
        errors[t] = 0;
      end
    end else if (!o_done) begin
      if (i_retire.valid === 1'b1) begin
        check_record();
      end else begin
        if (i_retire.valid !== 1'b0) begin
          errors[4]++;
          $display("retire valid is unknown at %0t", $time);
        end
        if (o_retired == 0) begin  // nothing may touch data memory before the first retire
          check_word(0, "o_dmem_ren", 32'(i_dmem_ren), 32'd0);
          check_word(0, "o_dmem_wen", 32'(i_dmem_wen), 32'd0);
        end
      end
    end
    bus_ren_q  = i_dmem_ren;  // the record retiring at the next edge is in memory now
    bus_wen_q  = i_dmem_wen;
    bus_mask_q = i_dmem_mask;
    o_checks = 0;
    o_errors = 0;
    for (int t = 0; t < 5; t++) begin
      o_checks += checks[t];
      o_errors += errors[t];
    end
  end

endmodule

`default_nettype wire

// File: rtl/hart.sv
`timescale 1ns/1ps
`default_nettype none

module hart (
  input  wire                    i_clk,
  input  wire                    i_rst,
  input  wire hart_pkg::word_t   i_imem_rdata,
  input  wire hart_pkg::word_t   i_dmem_rdata,
  output hart_pkg::word_t        o_imem_raddr,
  output hart_pkg::word_t        o_dmem_addr,
  output hart_pkg::word_t        o_dmem_wdata,
  output logic                   o_dmem_ren,
  output logic                   o_dmem_wen,
  output logic [3:0]             o_dmem_mask,
  output hart_pkg::retire_t      o_retire
);

  logic                 stall;  // holds fetch and decode, bubbles execute
  logic                 fd_valid;
  hart_pkg::word_t      fd_pc;
  hart_pkg::reg_addr_t  rs1_raddr, rs2_raddr;
  hart_pkg::word_t      rs1_rdata, rs2_rdata;
  hart_pkg::id_ex_t     id_ex;
  hart_pkg::ex_mem_t    ex_mem;
  logic                 rd_wen;
  hart_pkg::reg_addr_t  rd_waddr;
  hart_pkg::word_t      rd_wdata;

  fetch_stage i_fetch (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_stall    (stall),
    .o_pc       (o_imem_raddr),
    .o_fd_valid (fd_valid),
    .o_fd_pc    (fd_pc)
  );

  decode_stage i_decode (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_stall     (stall),
    .i_fd_valid  (fd_valid),
    .i_fd_pc     (fd_pc),
    .i_inst      (i_imem_rdata),
    .i_rs1_rdata (rs1_rdata),
    .i_rs2_rdata (rs2_rdata),
    .o_rs1_raddr (rs1_raddr),
    .o_rs2_raddr (rs2_raddr),
    .o_id_ex     (id_ex)
  );

  reg_file i_reg_file (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rs1_raddr (rs1_raddr),
    .i_rs2_raddr (rs2_raddr),
    .i_rd_waddr  (rd_waddr),
    .i_rd_wen    (rd_wen),
    .i_rd_wdata  (rd_wdata),
    .o_rs1_rdata (rs1_rdata),
    .o_rs2_rdata (rs2_rdata)
  );

  hazard_unit i_hazard (
    .i_fd_valid  (fd_valid),
    .i_rs1_raddr (rs1_raddr),
    .i_rs2_raddr (rs2_raddr),
    .i_id_ex     (id_ex),
    .i_ex_mem    (ex_mem),
    .o_stall     (stall)
  );

  execute_stage i_execute (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_id_ex  (id_ex),
    .o_ex_mem (ex_mem)
  );

  mem_wb_stage i_mem_wb (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_ex_mem     (ex_mem),
    .i_dmem_rdata (i_dmem_rdata),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_ren   (o_dmem_ren),
    .o_dmem_wen   (o_dmem_wen),
    .o_dmem_mask  (o_dmem_mask),
    .o_rd_wen     (rd_wen),
    .o_rd_waddr   (rd_waddr),
    .o_rd_wdata   (rd_wdata),
    .o_retire     (o_retire)
  );

endmodule

`default_nettype wire

// File: rtl/mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
  input  wire                     i_clk,
  input  wire                     i_rst,
  input  wire hart_pkg::ex_mem_t  i_ex_mem,
  input  wire hart_pkg::word_t    i_dmem_rdata,  // answers the address of the previous edge
  output hart_pkg::word_t         o_dmem_addr,
  output hart_pkg::word_t         o_dmem_wdata,
  output logic                    o_dmem_ren,
  output logic                    o_dmem_wen,
  output logic [3:0]              o_dmem_mask,
  output logic                    o_rd_wen,
  output hart_pkg::reg_addr_t     o_rd_waddr,
  output hart_pkg::word_t         o_rd_wdata,
  output hart_pkg::retire_t       o_retire
);

  hart_pkg::ex_mem_t wb_q;  // instruction in writeback

  // memory stage, a store lands at the edge that ends this cycle
  assign o_dmem_addr  = i_ex_mem.result;
  assign o_dmem_wdata = i_ex_mem.store_data;
  assign o_dmem_ren   = i_ex_mem.valid && i_ex_mem.mem_read;
  assign o_dmem_wen   = i_ex_mem.valid && i_ex_mem.mem_write;
  assign o_dmem_mask  = hart_pkg::FULL_MASK;

  always_ff @(posedge i_clk) begin
    wb_q <= i_ex_mem;
    if (i_rst) begin
      wb_q.valid     <= 1'b0;
      wb_q.reg_write <= 1'b0;
      wb_q.mem_read  <= 1'b0;
      wb_q.mem_write <= 1'b0;
    end
  end

  assign o_rd_wen   = wb_q.valid && wb_q.reg_write;
  assign o_rd_waddr = wb_q.reg_write ? wb_q.rd : '0;  // stores and ebreak report x0
  assign o_rd_wdata = wb_q.mem_read ? i_dmem_rdata : wb_q.result;

  always_comb begin
    o_retire            = '0;
    o_retire.valid      = wb_q.valid;
    o_retire.inst       = wb_q.inst;
    o_retire.halt       = wb_q.inst == hart_pkg::EBREAK_INST;
    o_retire.rs1_raddr  = wb_q.rs1_raddr;
    o_retire.rs2_raddr  = wb_q.rs2_raddr;
    o_retire.rs1_rdata  = wb_q.rs1_rdata;
    o_retire.rs2_rdata  = wb_q.rs2_rdata;
    o_retire.rd_waddr   = o_rd_waddr;
    o_retire.rd_wdata   = o_rd_wdata;
    o_retire.pc         = wb_q.pc;
    o_retire.next_pc    = wb_q.pc + 32'd4;  // straight-line code only
    o_retire.dmem_addr  = wb_q.result;
    o_retire.dmem_mask  = hart_pkg::FULL_MASK;
    o_retire.dmem_ren   = wb_q.mem_read;
    o_retire.dmem_wen   = wb_q.mem_write;
    o_retire.dmem_rdata = i_dmem_rdata;
    o_retire.dmem_wdata = wb_q.store_data;
  end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  wire                    i_clk,
  input  wire                    i_rst,
  input  wire hart_pkg::id_ex_t  i_id_ex,
  output hart_pkg::ex_mem_t      o_ex_mem
);

  hart_pkg::word_t a, b;
  hart_pkg::word_t result;
  logic [4:0]      shamt;

  assign a     = i_id_ex.op_a;
  assign b     = i_id_ex.op_b;
  assign shamt = b[4:0];  // shifts use the low five bits only

  always_comb begin
    case (i_id_ex.alu_op)
      hart_pkg::ALU_SUB:  result = a - b;
      hart_pkg::ALU_AND:  result = a & b;
      hart_pkg::ALU_OR:   result = a | b;
      hart_pkg::ALU_XOR:  result = a ^ b;
      hart_pkg::ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
      hart_pkg::ALU_SLTU: result = {31'd0, a < b};
      hart_pkg::ALU_SLL:  result = a << shamt;
      hart_pkg::ALU_SRL:  result = a >> shamt;
      hart_pkg::ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
      default:            result = a + b;  // add, lui and load/store address
    endcase
  end

  always_ff @(posedge i_clk) begin
    o_ex_mem.pc         <= i_id_ex.pc;
    o_ex_mem.inst       <= i_id_ex.inst;
    o_ex_mem.rs1_raddr  <= i_id_ex.rs1_raddr;
    o_ex_mem.rs2_raddr  <= i_id_ex.rs2_raddr;
    o_ex_mem.rs1_rdata  <= i_id_ex.rs1_rdata;
    o_ex_mem.rs2_rdata  <= i_id_ex.rs2_rdata;
    o_ex_mem.result     <= result;
    o_ex_mem.rd         <= i_id_ex.rd;
    o_ex_mem.store_data <= i_id_ex.store_data;
    if (i_rst) begin
      o_ex_mem.valid     <= 1'b0;
      o_ex_mem.reg_write <= 1'b0;
      o_ex_mem.mem_read  <= 1'b0;
      o_ex_mem.mem_write <= 1'b0;
    end else begin
      o_ex_mem.valid     <= i_id_ex.valid;
      o_ex_mem.reg_write <= i_id_ex.reg_write;
      o_ex_mem.mem_read  <= i_id_ex.mem_read;
      o_ex_mem.mem_write <= i_id_ex.mem_write;
    end
  end

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  wire                       i_fd_valid,
  input  wire hart_pkg::reg_addr_t  i_rs1_raddr,
  input  wire hart_pkg::reg_addr_t  i_rs2_raddr,
  input  wire hart_pkg::id_ex_t     i_id_ex,
  input  wire hart_pkg::ex_mem_t    i_ex_mem,
  output logic                      o_stall
);

  logic rs1_busy, rs2_busy;

  // true when an older instruction has yet to write the source register
  function automatic logic pending(input logic v, input logic w,
                                   input hart_pkg::reg_addr_t rd,
                                   input hart_pkg::reg_addr_t rs);
    pending = v && w && rs != '0 && rd == rs;
  endfunction

  // writeback is not checked, the register file bypass covers it
  assign rs1_busy = pending(i_id_ex.valid, i_id_ex.reg_write, i_id_ex.rd, i_rs1_raddr) ||
                    pending(i_ex_mem.valid, i_ex_mem.reg_write, i_ex_mem.rd, i_rs1_raddr);
  assign rs2_busy = pending(i_id_ex.valid, i_id_ex.reg_write, i_id_ex.rd, i_rs2_raddr) ||
                    pending(i_ex_mem.valid, i_ex_mem.reg_write, i_ex_mem.rd, i_rs2_raddr);

  assign o_stall = i_fd_valid && (rs1_busy || rs2_busy);

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire                       i_clk,
  input  wire                       i_rst,
  input  wire hart_pkg::reg_addr_t  i_rs1_raddr,
  input  wire hart_pkg::reg_addr_t  i_rs2_raddr,
  input  wire hart_pkg::reg_addr_t  i_rd_waddr,
  input  wire                       i_rd_wen,
  input  wire hart_pkg::word_t      i_rd_wdata,
  output hart_pkg::word_t           o_rs1_rdata,
  output hart_pkg::word_t           o_rs2_rdata
);

  hart_pkg::word_t regs [1:31];  // x0 has no storage

  // x0 reads zero, a same-cycle write is passed straight through
  function automatic hart_pkg::word_t read_port(input hart_pkg::reg_addr_t addr);
    if (addr == '0) begin
      read_port = '0;
    end else if (i_rd_wen && i_rd_waddr == addr) begin
      read_port = i_rd_wdata;
    end else begin
      read_port = regs[addr];
    end
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen && i_rd_waddr != '0) begin
      regs[i_rd_waddr] <= i_rd_wdata;  // writes to x0 are dropped
    end
  end

  always_comb begin
    o_rs1_rdata = read_port(i_rs1_raddr);
    o_rs2_rdata = read_port(i_rs2_raddr);
  end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  wire                   i_clk,
  input  wire                   i_rst,
  input  wire                   i_stall,
  input  wire                   i_fd_valid,
  input  wire hart_pkg::word_t  i_fd_pc,
  input  wire hart_pkg::word_t  i_inst,
  input  wire hart_pkg::word_t  i_rs1_rdata,
  input  wire hart_pkg::word_t  i_rs2_rdata,
  output hart_pkg::reg_addr_t   o_rs1_raddr,
  output hart_pkg::reg_addr_t   o_rs2_raddr,
  output hart_pkg::id_ex_t      o_id_ex
);

  hart_pkg::word_t     inst_q;  // last word decode worked on
  logic                held_q;  // set when the previous edge was stalled
  hart_pkg::word_t     inst;
  logic [6:0]          opcode;
  logic [2:0]          funct3;
  hart_pkg::word_t     imm_i, imm_s, imm_u;
  hart_pkg::word_t     imm;  // immediate picked for operand b
  logic                use_rs1, use_rs2;
  logic                b_is_reg;  // register-register format
  hart_pkg::alu_op_e   alu_op;
  logic                reg_write, mem_read, mem_write;
  hart_pkg::id_ex_t    id_ex_d;

  // funct3 plus the bit 30 modifier select the alu function
  function automatic hart_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_sel = alt ? hart_pkg::ALU_SUB : hart_pkg::ALU_ADD;
      3'b001:  alu_sel = hart_pkg::ALU_SLL;
      3'b010:  alu_sel = hart_pkg::ALU_SLT;
      3'b011:  alu_sel = hart_pkg::ALU_SLTU;
      3'b100:  alu_sel = hart_pkg::ALU_XOR;
      3'b101:  alu_sel = alt ? hart_pkg::ALU_SRA : hart_pkg::ALU_SRL;
      3'b110:  alu_sel = hart_pkg::ALU_OR;
      default: alu_sel = hart_pkg::ALU_AND;
    endcase
  endfunction

  // once stalled the memory has already moved to the next word, so the held copy is used
  assign inst = held_q ? inst_q : i_inst;

  always_ff @(posedge i_clk) begin
    inst_q <= inst;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      held_q <= 1'b0;
    end else begin
      held_q <= i_stall;
    end
  end

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign imm_i  = {{20{inst[31]}}, inst[31:20]};
  assign imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u  = {inst[31:12], 12'd0};

  always_comb begin
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    b_is_reg  = 1'b0;
    imm       = imm_i;
    alu_op    = hart_pkg::ALU_ADD;  // addresses and lui use the adder
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    case (opcode)
      hart_pkg::OPCODE_OP: begin
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        b_is_reg  = 1'b1;
        alu_op    = alu_sel(funct3, inst[30]);
        reg_write = 1'b1;
      end
      hart_pkg::OPCODE_OP_IMM: begin
        use_rs1   = 1'b1;
        alu_op    = alu_sel(funct3, funct3 == 3'b101 && inst[30]);  // only srai has alt
        reg_write = 1'b1;
      end
      hart_pkg::OPCODE_LUI: begin
        imm       = imm_u;  // rs1 reads as x0, so operand a is zero
        reg_write = 1'b1;
      end
      hart_pkg::OPCODE_LOAD: begin
        use_rs1   = 1'b1;
        reg_write = 1'b1;
        mem_read  = 1'b1;
      end
      hart_pkg::OPCODE_STORE: begin
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        imm       = imm_s;
        mem_write = 1'b1;
      end
      hart_pkg::OPCODE_SYSTEM: begin
        // ebreak has no side effects here, halt is flagged at retire
      end
      default: begin
      end
    endcase
  end

  // formats that do not read a source report x0
  assign o_rs1_raddr = use_rs1 ? inst[19:15] : '0;
  assign o_rs2_raddr = use_rs2 ? inst[24:20] : '0;

  always_comb begin
    id_ex_d            = '0;
    id_ex_d.valid      = 1'b1;
    id_ex_d.pc         = i_fd_pc;
    id_ex_d.inst       = inst;
    id_ex_d.alu_op     = alu_op;
    id_ex_d.op_a       = i_rs1_rdata;  // x0 reads zero, which covers lui
    id_ex_d.op_b       = b_is_reg ? i_rs2_rdata : imm;
    id_ex_d.rs1_raddr  = o_rs1_raddr;
    id_ex_d.rs2_raddr  = o_rs2_raddr;
    id_ex_d.rs1_rdata  = i_rs1_rdata;
    id_ex_d.rs2_rdata  = i_rs2_rdata;
    id_ex_d.rd         = inst[11:7];
    id_ex_d.reg_write  = reg_write;
    id_ex_d.mem_read   = mem_read;
    id_ex_d.mem_write  = mem_write;
    id_ex_d.store_data = i_rs2_rdata;
  end

  always_ff @(posedge i_clk) begin
    o_id_ex <= id_ex_d;
    if (i_rst || i_stall || !i_fd_valid) begin  // bubble into execute
      o_id_ex.valid     <= 1'b0;
      o_id_ex.inst      <= hart_pkg::NOP_INST;
      o_id_ex.reg_write <= 1'b0;
      o_id_ex.mem_read  <= 1'b0;
      o_id_ex.mem_write <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  wire             i_clk,
  input  wire             i_rst,
  input  wire             i_stall,
  output hart_pkg::word_t o_pc,  // also the instruction memory address
  output logic            o_fd_valid,
  output hart_pkg::word_t o_fd_pc
);

  // the memory samples o_pc at the edge and answers after it, so the pc and
  // valid flag are delayed by one register to meet the returning word
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_pc       <= hart_pkg::RESET_ADDR;
      o_fd_valid <= 1'b0;  // stays low through the first cycle after reset
    end else if (!i_stall) begin
      o_pc       <= o_pc + 32'd4;  // no branches, so the pc only walks forward
      o_fd_valid <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      o_fd_pc <= o_pc;  // pc of the word that arrives next cycle
    end
  end

endmodule

`default_nettype wire

// File: rtl/hart_pkg.sv
`default_nettype none

package hart_pkg;

  typedef logic [31:0] word_t;  // data, address or instruction word
  typedef logic [4:0] reg_addr_t;  // register index x0..x31

  localparam word_t RESET_ADDR = 32'h0000_0000;  // first fetch address

  // major opcodes of the executed subset
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
  localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
  localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
  localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

  localparam word_t EBREAK_INST = 32'h0010_0073;  // halt marker
  localparam word_t NOP_INST    = 32'h0000_0013;  // addi x0,x0,0 used for bubbles

  localparam logic [3:0] FULL_MASK = 4'b1111;  // only word accesses, all byte lanes

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  // decode to execute payload
  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     inst;
    alu_op_e   alu_op;
    word_t     op_a;
    word_t     op_b;
    reg_addr_t rs1_raddr;
    reg_addr_t rs2_raddr;
    word_t     rs1_rdata;
    word_t     rs2_rdata;
    reg_addr_t rd;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    word_t     store_data;
  } id_ex_t;

  // execute to memory payload, the alu result doubles as the memory address
  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     inst;
    reg_addr_t rs1_raddr;
    reg_addr_t rs2_raddr;
    word_t     rs1_rdata;
    word_t     rs2_rdata;
    word_t     result;
    reg_addr_t rd;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    word_t     store_data;
  } ex_mem_t;

  // one record per completed instruction
  typedef struct packed {
    logic      valid;
    word_t     inst;
    logic      halt;
    reg_addr_t rs1_raddr;
    reg_addr_t rs2_raddr;
    word_t     rs1_rdata;
    word_t     rs2_rdata;
    reg_addr_t rd_waddr;
    word_t     rd_wdata;
    word_t     pc;
    word_t     next_pc;
    word_t     dmem_addr;
    logic [3:0] dmem_mask;
    logic      dmem_ren;
    logic      dmem_wen;
    word_t     dmem_rdata;
    word_t     dmem_wdata;
  } retire_t;

endpackage

`default_nettype wire
